//--- common/spi_proto_pkg.sv
`default_nettype none

package spi_proto_pkg;

  // command byte, first byte of every frame
  localparam logic [7:0] cmd_write = 8'h00; // data bytes are written
  localparam logic [7:0] cmd_read  = 8'h01; // data bytes are read back on miso

  // byte address carried after the command
  localparam int addr_bits  = 32;
  localparam int addr_bytes = 4; // msb first

  // pin synchronizer depth in front of the edge detect
  localparam int sync_stages = 2;

endpackage

`default_nettype wire

//--- common/mem_map_pkg.sv
`default_nettype none

package mem_map_pkg;

  // region code sits in byte address bits 31:24
  localparam logic [7:0] region_mem  = 8'h00; // word memory
  localparam logic [7:0] region_ctrl = 8'hFF; // control register

  // anything else reads as 0x00 and ignores writes

  // word memory geometry
  localparam int word_bits      = 16;
  localparam int word_addr_bits = 10; // 1024 words, byte address bits 10:1

  // cycles from mem_re to valid mem_rdata
  localparam int read_latency = 2;

endpackage

`default_nettype wire

//--- spi_slave/spi_rw_slave.sv
`timescale 1ns/1ns
`default_nettype none

module spi_rw_slave
  import spi_proto_pkg::*;
(
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  csn,
  input  wire                  sclk,
  input  wire                  mosi,
  input  wire [7:0]            rdata,
  output logic                 miso,
  output logic                 rd,
  output logic                 wr,
  output logic [addr_bits-1:0] addr,
  output logic [7:0]           wdata
);

  typedef enum logic [1:0] {st_cmd, st_addr, st_data} state_t;

  logic [sync_stages-1:0] csn_sync;
  logic [sync_stages-1:0] sclk_sync;
  logic [sync_stages-1:0] mosi_sync;
  logic csn_s;
  logic sclk_s;
  logic mosi_s;
  logic sclk_prev;
  logic rise;
  logic fall;
  logic byte_done;
  state_t state;
  logic [2:0] bit_cnt;
  logic [2:0] byte_cnt; // address bytes seen
  logic is_read;
  logic is_write;
  logic load_pending; // next falling edge loads rdata
  logic [7:0] shift_in;
  logic [7:0] shift_out;
  logic [7:0] rx_byte;

  assign csn_s  = csn_sync[sync_stages-1];
  assign sclk_s = sclk_sync[sync_stages-1];
  assign mosi_s = mosi_sync[sync_stages-1];

  assign rise      = sclk_s & ~sclk_prev;
  assign fall      = ~sclk_s & sclk_prev;
  assign byte_done = rise & ~csn_s & (bit_cnt == 3'd7);
  assign rx_byte   = {shift_in[6:0], mosi_s};

  // drop miso as soon as the pin deasserts
  assign miso = ~(csn | csn_s) & shift_out[7];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      csn_sync     <= '1;
      sclk_sync    <= '0;
      mosi_sync    <= '0;
      sclk_prev    <= 1'b0;
      state        <= st_cmd;
      bit_cnt      <= 3'd0;
      byte_cnt     <= 3'd0;
      is_read      <= 1'b0;
      is_write     <= 1'b0;
      load_pending <= 1'b0;
      shift_out    <= 8'h00;
      rd           <= 1'b0;
      wr           <= 1'b0;
    end
    else
    begin
      csn_sync  <= {csn_sync[sync_stages-2:0], csn};
      sclk_sync <= {sclk_sync[sync_stages-2:0], sclk};
      mosi_sync <= {mosi_sync[sync_stages-2:0], mosi};
      sclk_prev <= sclk_s;
      rd <= 1'b0;
      wr <= 1'b0;
      if (csn_s)
      begin
        // frame over so any partial byte is thrown away
        state        <= st_cmd;
        bit_cnt      <= 3'd0;
        byte_cnt     <= 3'd0;
        load_pending <= 1'b0;
        shift_out    <= 8'h00;
      end
      else
      begin
        if (rise)
          bit_cnt <= bit_cnt + 3'd1;
        if (byte_done)
        begin
          case (state)
            st_cmd:
            begin
              is_read  <= (rx_byte == cmd_read);
              is_write <= (rx_byte == cmd_write);
              byte_cnt <= 3'd0;
              state    <= st_addr;
            end
            st_addr:
            begin
              byte_cnt <= byte_cnt + 3'd1;
              if (byte_cnt == 3'(addr_bytes - 1))
              begin
                state        <= st_data;
                rd           <= is_read; // fetch first byte
                load_pending <= is_read;
              end
            end
            st_data:
            begin
              wr           <= is_write;
              rd           <= is_read; // prefetch next byte
              load_pending <= is_read;
            end
            default: state <= st_cmd;
          endcase
        end
        if (fall)
        begin
          if (load_pending)
          begin
            shift_out    <= rdata;
            load_pending <= 1'b0;
          end
          else
            shift_out <= {shift_out[6:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rise && !csn_s)
      shift_in <= rx_byte;
    if (byte_done && state == st_addr)
      addr <= {addr[addr_bits-9:0], rx_byte}; // msb first
    else if (byte_done && state == st_data && is_read)
      addr <= addr + addr_bits'(1);
    else if (wr)
      addr <= addr + addr_bits'(1); // after the bridge took this byte
    if (byte_done && state == st_data)
      wdata <= rx_byte;
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr));
  a_no_wr_idle: assert property (@(posedge clk) disable iff (rst) csn_s |-> !wr);

endmodule

`default_nettype wire

//--- source/byte_word_bridge.sv
`timescale 1ns/1ns
`default_nettype none

module byte_word_bridge
  import spi_proto_pkg::*;
  import mem_map_pkg::*;
(
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       rd,
  input  wire                       wr,
  input  wire [addr_bits-1:0]       addr,
  input  wire [7:0]                 wdata,
  input  wire [word_bits-1:0]       mem_rdata,
  output logic [7:0]                rdata,
  output logic                      mem_we,
  output logic                      mem_re,
  output logic [word_addr_bits-1:0] mem_addr,
  output logic [word_bits-1:0]      mem_wdata,
  output logic [7:0]                control
);

  logic [7:0] region;
  logic is_mem;
  logic is_ctrl;
  logic [7:0] hold;      // even byte waiting for its odd partner
  logic [7:0] rd_region; // region of the read in flight
  logic rd_odd;

  assign region  = addr[addr_bits-1 -: 8];
  assign is_mem  = (region == region_mem);
  assign is_ctrl = (region == region_ctrl);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      mem_we    <= 1'b0;
      mem_re    <= 1'b0;
      hold      <= 8'h00;
      control   <= 8'h00;
      rd_region <= 8'h00;
      rd_odd    <= 1'b0;
    end
    else
    begin
      mem_we <= 1'b0;
      mem_re <= 1'b0;
      if (wr && is_mem)
      begin
        if (addr[0])
          mem_we <= 1'b1; // odd byte completes the word
        else
          hold <= wdata;
      end
      if (wr && is_ctrl)
        control <= wdata;
      if (rd)
      begin
        rd_region <= region;
        rd_odd    <= addr[0];
        mem_re    <= is_mem;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if ((wr || rd) && is_mem)
      mem_addr <= addr[word_addr_bits:1];
    if (wr && is_mem && addr[0])
      mem_wdata <= {hold, wdata}; // even byte is the high half
  end

  // read byte select, valid read_latency cycles after mem_re
  always_comb
  begin
    if (rd_region == region_mem)
    begin
      if (rd_odd)
        rdata = mem_rdata[7:0];
      else
        rdata = mem_rdata[word_bits-1 -: 8];
    end
    else if (rd_region == region_ctrl)
      rdata = control;
    else
      rdata = 8'h00; // unmapped region
  end

  a_we_re_excl: assert property (@(posedge clk) disable iff (rst) !(mem_we && mem_re));

endmodule

`default_nettype wire

//--- source/word_store.sv
`timescale 1ns/1ns
`default_nettype none

module word_store
  import mem_map_pkg::*;
(
  input  wire                      clk,
  input  wire                      mem_we,
  input  wire                      mem_re,
  input  wire [word_addr_bits-1:0] mem_addr,
  input  wire [word_bits-1:0]      mem_wdata,
  output logic [word_bits-1:0]     mem_rdata
);

  logic [word_bits-1:0] mem [2**word_addr_bits];
  logic [word_addr_bits-1:0] rd_addr_q;
  logic [read_latency-2:0] re_pipe; // read strobe delay line

  always_ff @(posedge clk)
  begin
    if (mem_we)
      mem[mem_addr] <= mem_wdata;
    if (mem_re)
      rd_addr_q <= mem_addr;
    re_pipe <= (read_latency - 1)'({re_pipe, mem_re});
  end

  // output stage holds the last word until the next read
  always_ff @(posedge clk)
  begin
    if (re_pipe[read_latency-2])
      mem_rdata <= mem[rd_addr_q];
  end

  a_we_addr_known: assert property (@(posedge clk) mem_we |-> !$isunknown(mem_addr));

endmodule

`default_nettype wire

//--- source/loader_top.sv
`timescale 1ns/1ns
`default_nettype none

module loader_top
  import spi_proto_pkg::*;
  import mem_map_pkg::*;
(
  input  wire        clk,
  input  wire        rst,
  input  wire        csn,
  input  wire        sclk,
  input  wire        mosi,
  output wire        miso,
  output wire [7:0]  control
);

  wire                      rd;
  wire                      wr;
  wire [addr_bits-1:0]      addr;
  wire [7:0]                wdata;
  wire [7:0]                rdata;
  wire                      mem_we;
  wire                      mem_re;
  wire [word_addr_bits-1:0] mem_addr;
  wire [word_bits-1:0]      mem_wdata;
  wire [word_bits-1:0]      mem_rdata;

  spi_rw_slave u_spi_rw_slave (
    .clk   (clk),
    .rst   (rst),
    .csn   (csn),
    .sclk  (sclk),
    .mosi  (mosi),
    .rdata (rdata),
    .miso  (miso),
    .rd    (rd),
    .wr    (wr),
    .addr  (addr),
    .wdata (wdata)
  );

  byte_word_bridge u_byte_word_bridge (
    .clk       (clk),
    .rst       (rst),
    .rd        (rd),
    .wr        (wr),
    .addr      (addr),
    .wdata     (wdata),
    .mem_rdata (mem_rdata),
    .rdata     (rdata),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .control   (control)
  );

  // stands in for the sdram controller
  word_store u_word_store (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_re    (mem_re),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

//--- verification/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// spi mode 0 master, sclk idles low, half periods counted in clk cycles
localparam int half_period = 4;
localparam int frame_gap   = 8; // csn high time between frames
localparam int idle_limit  = 64;

// a frame may only start out of reset with miso quiet
task automatic wait_bus_idle();
  int n;
  n = 0;
  while ((rst || miso) && n < idle_limit)
  begin
    @(negedge clk);
    n++;
  end
  if (rst || miso)
    abort_run("timed out waiting for reset release and a quiet miso before a frame");
  repeat (frame_gap) @(negedge clk);
endtask

// one byte, msb first; miso sampled just before each rising sclk
task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
  for (int i = 7; i >= 0; i--)
  begin
    mosi = tx[i];
    repeat (half_period) @(negedge clk);
    rx[i] = miso;
    sclk = 1'b1;
    repeat (half_period) @(negedge clk);
    sclk = 1'b0;
  end
endtask

task automatic open_frame(input logic [7:0] cmd, input logic [31:0] a);
  logic [7:0] rx;
  wait_bus_idle();
  csn = 1'b0;
  repeat (half_period) @(negedge clk);
  shift_byte(cmd, rx);
  for (int i = addr_bytes - 1; i >= 0; i--)
    shift_byte(a[8*i +: 8], rx); // address msb first
endtask

// returns right at the csn edge, the idle gap comes before the next frame
task automatic close_frame();
  repeat (half_period) @(negedge clk);
  csn  = 1'b1;
  mosi = 1'b0;
endtask

task automatic spi_write_frame(input logic [31:0] a, input logic [7:0] data[$]);
  logic [7:0] rx;
  open_frame(cmd_write, a);
  foreach (data[i])
    shift_byte(data[i], rx);
  close_frame();
endtask

task automatic spi_read_frame(input logic [31:0] a, input int count, output logic [7:0] got[$]);
  logic [7:0] rx;
  got = {};
  open_frame(cmd_read, a);
  repeat (count)
  begin
    shift_byte(8'h00, rx);
    got.push_back(rx);
  end
  close_frame();
endtask

`endif

//--- verification/tb_loader.sv
`timescale 1ns/1ns
`default_nettype none

module tb_loader
  import spi_proto_pkg::*;
  import mem_map_pkg::*;
();

  logic clk;
  logic rst;
  logic csn;
  logic sclk;
  logic mosi;
  wire miso;
  wire [7:0] control;

  integer seed;
  logic [word_bits-1:0] word_model [2**word_addr_bits]; // expected memory words
  logic [7:0] hold_model; // even byte waiting for its odd partner
  logic [7:0] ctrl_model;
  logic [7:0] data_q [$];
  logic [7:0] old_byte;

  loader_top u_loader_top (
    .clk     (clk),
    .rst     (rst),
    .csn     (csn),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso),
    .control (control)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  `include "tb_spi_tasks.svh"

  // pairing rule: even byte is held, odd byte writes {held, byte}
  function automatic void model_write(input logic [31:0] a, input logic [7:0] b);
    if (a[31:24] == region_mem)
    begin
      if (a[0])
        word_model[a[10:1]] = {hold_model, b};
      else
        hold_model = b;
    end
    else if (a[31:24] == region_ctrl)
      ctrl_model = b;
  endfunction

  function automatic logic [7:0] expect_byte(input logic [31:0] a);
    logic [15:0] w;
    if (a[31:24] == region_ctrl)
      return ctrl_model;
    if (a[31:24] != region_mem)
      return 8'h00; // unmapped
    w = word_model[a[10:1]];
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic write_and_model(input logic [31:0] a, input logic [7:0] data[$]);
    spi_write_frame(a, data);
    foreach (data[i])
      model_write(a + 32'(i), data[i]);
  endtask

  task automatic check_read(input logic [31:0] a, input int n);
    logic [7:0] got [$];
    logic [7:0] exp;
    spi_read_frame(a, n, got);
    foreach (got[i])
    begin
      exp = expect_byte(a + 32'(i));
      assert (got[i] === exp)
      else abort_run($sformatf("FAIL %0t: read at %h returned %h, expected %h",
                               $time, a + 32'(i), got[i], exp));
    end
  endtask

  task automatic random_bytes(input int n, output logic [7:0] q[$]);
    q = {};
    repeat (n) q.push_back(8'($random(seed)));
  endtask

  a_miso_idle: assert property (@(posedge clk) disable iff (rst) csn |-> !miso)
    else abort_run($sformatf("FAIL %0t: miso high while csn is high", $time));
  a_control_model: assert property (@(posedge clk) disable iff (rst)
                                    csn |-> control == ctrl_model)
    else abort_run($sformatf("FAIL %0t: control is %h, expected %h", $time, control, ctrl_model));

  initial
  begin
    seed = 32'hee039c22;
    rst  = 1'b1;
    csn  = 1'b1;
    sclk = 1'b0;
    mosi = 1'b0;
    hold_model = 8'h00;
    ctrl_model = 8'h00;
    repeat (16) @(negedge clk);
    rst = 1'b0;

    assert (control === 8'h00)
    else abort_run($sformatf("FAIL %0t: control is %h after reset", $time, control));

    // burst into word memory from an even address
    random_bytes(16, data_q);
    write_and_model(32'h0000_0040, data_q);
    check_read(32'h0000_0040, 16);

    random_bytes(1, data_q);
    data_q[0] = data_q[0] | 8'h80; // must differ from the reset value
    write_and_model({region_ctrl, 24'h00_0000}, data_q);
    assert (control === data_q[0])
    else abort_run($sformatf("FAIL %0t: control is %h, expected %h", $time, control, data_q[0]));
    check_read({region_ctrl, 24'h00_0000}, 1);

    // lone even byte must not reach memory
    old_byte = expect_byte(32'h0000_0044);
    data_q = {~old_byte};
    write_and_model(32'h0000_0044, data_q);
    check_read(32'h0000_0044, 2);

    random_bytes(4, data_q);
    write_and_model(32'h1200_0040, data_q);
    assert (control === ctrl_model)
    else abort_run($sformatf("FAIL %0t: control changed to %h", $time, control));
    check_read(32'h0000_0040, 16);
    check_read(32'h1200_0040, 2);

    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verification
common/spi_proto_pkg.sv
common/mem_map_pkg.sv
spi_slave/spi_rw_slave.sv
source/byte_word_bridge.sv
source/word_store.sv
source/loader_top.sv
verification/tb_loader.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_loader
FILELIST   := sim.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
